// File: compile.f
+incdir+verilog
verilog/cachePkg.sv
verilog/cacheArrays.sv
verilog/lineBuffer.sv
verilog/cacheController.sv
verilog/dataCacheTop.sv
verif/memResponder.sv
verif/tbDataCache.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tbDataCache
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tbDataCache.sv
// Testbench for the two-way data cache
// Clock, reset, directed replacement sequence and random reads and writes
// Reference model of memory and per-set valid, tag and MRU state

`timescale 1ns/10ps

module tbDataCache;

    localparam int numOps = 400;
    localparam int directedOps = 6;
    localparam int cyclesPerOp = 60;
    localparam int timeoutCycles = (numOps + directedOps) * cyclesPerOp;
    localparam int maxDelay = 3;
    localparam int memWords = 512;
    localparam integer seedInit = 42;

    logic rwArbiterCacheBus;
    logic rst;
    logic coreReqCyc;
    cachePkg::addrT coreReq;
    cachePkg::coreOpE coreReqOp;
    cachePkg::wordT coreReqData;
    logic coreReqAck;
    logic coreRespCyc;
    cachePkg::wordT coreResp;
    logic coreRespAck;
    logic memReqCyc;
    cachePkg::addrT memReq;
    logic memReqWrite;
    logic memReqAck;
    logic memRespCyc;
    cachePkg::wordT memResp;
    logic memRespAck;

    integer seed;
    int errors;
    int checks;
    int cycleCount;
    int predictedMisses;

    // Reference model, tags limited to two bits by the address range
    cachePkg::wordT modelMem [memWords];
    logic modelValid [16][2];
    logic [1:0] modelTag [16][2];
    logic modelMru [16];

    dataCacheTop dut0 (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rst(rst),
        .coreReqCyc(coreReqCyc), .coreReq(coreReq), .coreReqOp(coreReqOp),
        .coreReqData(coreReqData), .coreReqAck(coreReqAck),
        .coreRespCyc(coreRespCyc), .coreResp(coreResp), .coreRespAck(coreRespAck),
        .memReqCyc(memReqCyc), .memReq(memReq), .memReqWrite(memReqWrite),
        .memReqAck(memReqAck), .memRespCyc(memRespCyc), .memResp(memResp),
        .memRespAck(memRespAck)
    );

    memResponder #(.maxDelay(maxDelay), .memWords(memWords), .seedInit(seedInit)) mem0 (
        .rwArbiterCacheBus(rwArbiterCacheBus),
        .memReqCyc(memReqCyc), .memReq(memReq), .memReqWrite(memReqWrite),
        .memReqAck(memReqAck), .memRespCyc(memRespCyc), .memResp(memResp),
        .memRespAck(memRespAck)
    );

    initial begin
        rwArbiterCacheBus = 1'b0;
        forever #4 rwArbiterCacheBus = ~rwArbiterCacheBus;
    end

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error %s: got 0x%h expected 0x%h at %0t", name, got, expected, $time);
        end
    endtask

    // Hit test and allocation, invalid way first, else the LRU way
    task automatic predictAccess(input logic [8:0] wordAddr, output logic isHit);
        int setIdx;
        int way;
        logic [1:0] tagVal;
        setIdx = int'(wordAddr[6:3]);
        tagVal = wordAddr[8:7];
        isHit = 1'b0;
        way = 0;
        for (int w = 0; w < 2; w++) begin
            if (modelValid[setIdx][w] && modelTag[setIdx][w] == tagVal) begin
                isHit = 1'b1;
                way = w;
            end
        end
        if (!isHit) begin
            if (!modelValid[setIdx][0]) begin
                way = 0;
            end else if (!modelValid[setIdx][1]) begin
                way = 1;
            end else begin
                way = modelMru[setIdx] ? 0 : 1;
            end
            modelValid[setIdx][way] = 1'b1;
            modelTag[setIdx][way] = tagVal;
        end
        modelMru[setIdx] = (way == 1);
    endtask

    // Full core transaction with response checks
    task automatic coreAccess(input cachePkg::coreOpE op, input logic [8:0] wordAddr,
                              input cachePkg::wordT data);
        logic predictedHit;
        int latency;
        int respDelay;
        int lineBase;
        cachePkg::wordT heldResp;
        predictAccess(wordAddr, predictedHit);
        if (!predictedHit) begin
            predictedMisses++;
        end
        if (op == cachePkg::opWrite) begin
            modelMem[wordAddr] = data;
        end
        @(posedge rwArbiterCacheBus);
        #1 coreReqCyc = 1'b1;
        coreReq = cachePkg::addrT'({wordAddr, 3'b000});
        coreReqOp = op;
        coreReqData = data;
        @(negedge rwArbiterCacheBus);
        while (!coreReqAck) begin
            @(negedge rwArbiterCacheBus);
        end
        @(posedge rwArbiterCacheBus);
        #1 coreReqCyc = 1'b0;
        // Cycles counted from the ack cycle
        latency = 1;
        @(negedge rwArbiterCacheBus);
        while (!coreRespCyc) begin
            latency++;
            @(negedge rwArbiterCacheBus);
        end
        if (predictedHit && op == cachePkg::opRead) begin
            checkValue("coreRespCyc latency", 64'(latency), 64'd2);
        end
        if (op == cachePkg::opRead) begin
            checkValue("coreResp", coreResp, modelMem[wordAddr]);
        end else begin
            // Whole line written through by now
            lineBase = int'({wordAddr[8:3], 3'b000});
            for (int i = 0; i < 8; i++) begin
                checkValue("mem0.memArr", mem0.memArr[lineBase + i], modelMem[lineBase + i]);
            end
        end
        // Back-pressure, response held while ack withheld
        heldResp = coreResp;
        respDelay = {$random(seed)} % (maxDelay + 1);
        repeat (respDelay) begin
            @(negedge rwArbiterCacheBus);
            checkValue("coreRespCyc", 64'(coreRespCyc), 64'd1);
            checkValue("coreResp", coreResp, heldResp);
        end
        @(posedge rwArbiterCacheBus);
        #1 coreRespAck = 1'b1;
        @(posedge rwArbiterCacheBus);
        #1 coreRespAck = 1'b0;
        @(negedge rwArbiterCacheBus);
        checkValue("coreRespCyc", 64'(coreRespCyc), 64'd0);
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge rwArbiterCacheBus);
            cycleCount++;
        end
        $display("Run timed out after %0d cycles with the test still going", cycleCount);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [8:0] wordAddr;
        logic [8:0] lastWriteAddr;
        logic lastWasWrite;
        int fillsBefore;
        cachePkg::coreOpE op;
        cachePkg::wordT data;
        seed = seedInit;
        errors = 0;
        checks = 0;
        predictedMisses = 0;
        lastWasWrite = 1'b0;
        lastWriteAddr = '0;
        rst = 1'b1;
        coreReqCyc = 1'b0;
        coreReq = '0;
        coreReqOp = cachePkg::opRead;
        coreReqData = '0;
        coreRespAck = 1'b0;
        for (int s = 0; s < 16; s++) begin
            modelValid[s][0] = 1'b0;
            modelValid[s][1] = 1'b0;
            modelMru[s] = 1'b0;
        end
        repeat (3) @(posedge rwArbiterCacheBus);
        #1 rst = 1'b0;
        for (int i = 0; i < memWords; i++) begin
            modelMem[i] = mem0.memArr[i];
        end
        // Quiet outputs before the first request
        @(negedge rwArbiterCacheBus);
        checkValue("coreReqAck", 64'(coreReqAck), 64'd0);
        checkValue("coreRespCyc", 64'(coreRespCyc), 64'd0);
        checkValue("memReqCyc", 64'(memReqCyc), 64'd0);
        checkValue("memRespAck", 64'(memRespAck), 64'd0);

        // A, B, A, C in set 5, then A stays and B was evicted
        coreAccess(cachePkg::opRead, {2'd0, 4'd5, 3'd2}, '0);
        coreAccess(cachePkg::opRead, {2'd1, 4'd5, 3'd2}, '0);
        coreAccess(cachePkg::opRead, {2'd0, 4'd5, 3'd2}, '0);
        coreAccess(cachePkg::opRead, {2'd2, 4'd5, 3'd2}, '0);
        fillsBefore = mem0.fillCount;
        coreAccess(cachePkg::opRead, {2'd0, 4'd5, 3'd2}, '0);
        checkValue("mem0.fillCount", 64'(mem0.fillCount), 64'(fillsBefore));
        coreAccess(cachePkg::opRead, {2'd1, 4'd5, 3'd2}, '0);
        checkValue("mem0.fillCount", 64'(mem0.fillCount), 64'(fillsBefore + 1));

        for (int n = 0; n < numOps; n++) begin
            wordAddr = 9'($random(seed));
            op = ($random(seed) & 1) ? cachePkg::opWrite : cachePkg::opRead;
            data = {$random(seed), $random(seed)};
            // Often read back the word just written
            if (lastWasWrite && ($random(seed) & 1)) begin
                wordAddr = lastWriteAddr;
                op = cachePkg::opRead;
            end
            coreAccess(op, wordAddr, data);
            lastWasWrite = (op == cachePkg::opWrite);
            lastWriteAddr = wordAddr;
        end

        checkValue("mem0.fillCount", 64'(mem0.fillCount), 64'(predictedMisses));
        $display("Finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verif/memResponder.sv
// Testbench memory on the cache's arbiter bus
// Answers line fills and absorbs write-through beats
// Random delays before each acknowledge or fill beat, counts fills

`timescale 1ns/10ps

module memResponder #(
    parameter int maxDelay = 3,
    parameter int memWords = 512,
    parameter integer seedInit = 42
) (
    input  logic              rwArbiterCacheBus,
    input  logic              memReqCyc,
    input  cachePkg::addrT    memReq,
    input  logic              memReqWrite,
    output logic              memReqAck,
    output logic              memRespCyc,
    output cachePkg::wordT    memResp,
    input  logic              memRespAck
);

    localparam int wordAddrBits = $clog2(memWords);

    cachePkg::wordT memArr [memWords];
    int fillCount;
    integer seed;

    // Pattern mixes every address bit into the word
    function automatic cachePkg::wordT initWord(input int idx);
        return {16'hD47A, 16'(idx), 16'(~idx), 16'(idx * 16'h9E37)};
    endfunction

    task automatic randomWait();
        int delay;
        delay = {$random(seed)} % (maxDelay + 1);
        repeat (delay) @(posedge rwArbiterCacheBus);
    endtask

    // One request beat, acked for a single cycle
    task automatic ackBeat(output cachePkg::addrT beat);
        randomWait();
        @(posedge rwArbiterCacheBus);
        #1 memReqAck = 1'b1;
        @(negedge rwArbiterCacheBus);
        beat = memReq;
        @(posedge rwArbiterCacheBus);
        #1 memReqAck = 1'b0;
    endtask

    // Eight write-through data beats land in the array
    task automatic absorbLine(input int base);
        cachePkg::addrT data;
        for (int i = 0; i < 8; i++) begin
            ackBeat(data);
            memArr[base + i] = data;
        end
    endtask

    // Eight fill beats, next one only after the cache's ack
    task automatic sendLine(input int base);
        for (int i = 0; i < 8; i++) begin
            randomWait();
            @(posedge rwArbiterCacheBus);
            #1 memRespCyc = 1'b1;
            memResp = memArr[base + i];
            @(negedge rwArbiterCacheBus);
            while (!memRespAck) begin
                @(negedge rwArbiterCacheBus);
            end
            @(posedge rwArbiterCacheBus);
            #1 memRespCyc = 1'b0;
        end
    endtask

    initial begin
        cachePkg::addrT lineAddr;
        logic isWrite;
        int base;
        memReqAck = 1'b0;
        memRespCyc = 1'b0;
        memResp = '0;
        fillCount = 0;
        seed = seedInit;
        for (int i = 0; i < memWords; i++) begin
            memArr[i] = initWord(i);
        end
        forever begin
            @(negedge rwArbiterCacheBus);
            if (memReqCyc) begin
                isWrite = memReqWrite;
                ackBeat(lineAddr);
                // Word address of the line start
                base = int'(lineAddr[3 +: wordAddrBits]);
                if (isWrite) begin
                    absorbLine(base);
                end else begin
                    fillCount++;
                    sendLine(base);
                end
            end
        end
    end

endmodule

// File: verilog/dataCacheTop.sv
// Top level of the two-way data cache
// Set arrays, line buffer and controller
// Core request/response bus and memory arbiter bus

`timescale 1ns/10ps

module dataCacheTop (
    input  logic              rwArbiterCacheBus,
    input  logic              rst,
    input  logic              coreReqCyc,
    input  cachePkg::addrT    coreReq,
    input  cachePkg::coreOpE  coreReqOp,
    input  cachePkg::wordT    coreReqData,
    output logic              coreReqAck,
    output logic              coreRespCyc,
    output cachePkg::wordT    coreResp,
    input  logic              coreRespAck,
    output logic              memReqCyc,
    output cachePkg::addrT    memReq,
    output logic              memReqWrite,
    input  logic              memReqAck,
    input  logic              memRespCyc,
    input  cachePkg::wordT    memResp,
    output logic              memRespAck
);

    // Array side
    cachePkg::indexT rdIndex;
    cachePkg::tagT rdTag;
    logic wrEn;
    cachePkg::wayT wrWay;
    cachePkg::indexT wrIndex;
    cachePkg::tagT wrTag;
    cachePkg::lineT wrLine;
    logic invalidateEn;
    logic mruEn;
    cachePkg::wayT mruWay;
    logic hit;
    cachePkg::wayT hitWay;
    cachePkg::wayT victimWay;
    cachePkg::lineT way0Line;
    cachePkg::lineT way1Line;

    // Line buffer side
    logic loadEn;
    cachePkg::lineT loadLine;
    logic beatEn;
    cachePkg::wordSelT beatSel;
    cachePkg::wordT beatData;
    logic mergeEn;
    cachePkg::wordSelT mergeSel;
    cachePkg::wordT mergeData;
    cachePkg::wordSelT outSel;
    cachePkg::lineT line;
    cachePkg::wordT word;

    cacheArrays arrays0 (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rst(rst),
        .rdIndex(rdIndex), .rdTag(rdTag),
        .wrEn(wrEn), .wrWay(wrWay), .wrIndex(wrIndex), .wrTag(wrTag), .wrLine(wrLine),
        .invalidateEn(invalidateEn), .mruEn(mruEn), .mruWay(mruWay),
        .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
        .way0Line(way0Line), .way1Line(way1Line)
    );

    lineBuffer lineBuf0 (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rst(rst),
        .loadEn(loadEn), .loadLine(loadLine),
        .beatEn(beatEn), .beatSel(beatSel), .beatData(beatData),
        .mergeEn(mergeEn), .mergeSel(mergeSel), .mergeData(mergeData),
        .outSel(outSel), .line(line), .word(word)
    );

    cacheController ctrl0 (
        .rwArbiterCacheBus(rwArbiterCacheBus), .rst(rst),
        .coreReqCyc(coreReqCyc), .coreReq(coreReq), .coreReqOp(coreReqOp),
        .coreReqData(coreReqData), .coreRespAck(coreRespAck),
        .memReqAck(memReqAck), .memRespCyc(memRespCyc), .memResp(memResp),
        .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
        .way0Line(way0Line), .way1Line(way1Line), .line(line), .word(word),
        .coreReqAck(coreReqAck), .coreRespCyc(coreRespCyc), .coreResp(coreResp),
        .memReqCyc(memReqCyc), .memReq(memReq), .memReqWrite(memReqWrite),
        .memRespAck(memRespAck),
        .rdIndex(rdIndex), .rdTag(rdTag),
        .wrEn(wrEn), .wrWay(wrWay), .wrIndex(wrIndex), .wrTag(wrTag), .wrLine(wrLine),
        .invalidateEn(invalidateEn), .mruEn(mruEn), .mruWay(mruWay),
        .loadEn(loadEn), .loadLine(loadLine),
        .beatEn(beatEn), .beatSel(beatSel), .beatData(beatData),
        .mergeEn(mergeEn), .mergeSel(mergeSel), .mergeData(mergeData),
        .outSel(outSel)
    );

endmodule

// File: verilog/cacheController.sv
// Sequencing FSM of the data cache
// Core accept and response, memory fill and write-through
// Beat counting, array and line buffer commands

`timescale 1ns/10ps

`include "cache_consts.svh"

module cacheController (
    input  logic                rwArbiterCacheBus,
    input  logic                rst,
    input  logic                coreReqCyc,
    input  cachePkg::addrT      coreReq,
    input  cachePkg::coreOpE    coreReqOp,
    input  cachePkg::wordT      coreReqData,
    input  logic                coreRespAck,
    input  logic                memReqAck,
    input  logic                memRespCyc,
    input  cachePkg::wordT      memResp,
    input  logic                hit,
    input  cachePkg::wayT       hitWay,
    input  cachePkg::wayT       victimWay,
    input  cachePkg::lineT      way0Line,
    input  cachePkg::lineT      way1Line,
    input  cachePkg::lineT      line,
    input  cachePkg::wordT      word,
    output logic                coreReqAck,
    output logic                coreRespCyc,
    output cachePkg::wordT      coreResp,
    output logic                memReqCyc,
    output cachePkg::addrT      memReq,
    output logic                memReqWrite,
    output logic                memRespAck,
    output cachePkg::indexT     rdIndex,
    output cachePkg::tagT       rdTag,
    output logic                wrEn,
    output cachePkg::wayT       wrWay,
    output cachePkg::indexT     wrIndex,
    output cachePkg::tagT       wrTag,
    output cachePkg::lineT      wrLine,
    output logic                invalidateEn,
    output logic                mruEn,
    output cachePkg::wayT       mruWay,
    output logic                loadEn,
    output cachePkg::lineT      loadLine,
    output logic                beatEn,
    output cachePkg::wordSelT   beatSel,
    output cachePkg::wordT      beatData,
    output logic                mergeEn,
    output cachePkg::wordSelT   mergeSel,
    output cachePkg::wordT      mergeData,
    output cachePkg::wordSelT   outSel
);

    localparam int selLsb = `CACHE_OFFSET_BITS - `CACHE_WORD_SEL_BITS;
    localparam logic [`CACHE_WORD_SEL_BITS:0] lineBeats = `CACHE_LINE_WORDS;

    cachePkg::cacheStateE state;

    // Latched request
    cachePkg::addrT reqAddr;
    cachePkg::coreOpE reqOp;
    cachePkg::wordT reqData;
    cachePkg::tagT reqTag;
    cachePkg::indexT reqIndex;
    cachePkg::wordSelT reqSel;

    // Way being served, used for array writes and the MRU update
    cachePkg::wayT accWay;
    logic [`CACHE_WORD_SEL_BITS:0] beatCnt;
    logic isWrite;
    logic fillEnd;
    cachePkg::lineT hitLine;

    assign reqTag = reqAddr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    assign reqIndex = reqAddr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    assign reqSel = reqAddr[selLsb +: `CACHE_WORD_SEL_BITS];
    assign isWrite = (reqOp == cachePkg::opWrite);
    assign hitLine = hitWay ? way1Line : way0Line;

    // Accept only when idle; one cycle since the state moves on
    assign coreReqAck = (state == cachePkg::stIdle) && coreReqCyc;

    // Set is read in the accept cycle, compared in stLookup
    assign rdIndex = coreReqAck ? coreReq[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS] : reqIndex;
    assign rdTag = reqTag;

    // Memory request side
    assign memReqCyc = state inside {cachePkg::stFillReq, cachePkg::stWriteAddr,
                                     cachePkg::stWriteData};
    assign memReqWrite = state inside {cachePkg::stWriteAddr, cachePkg::stWriteData};
    assign memReq = (state == cachePkg::stWriteData) ?
                    word : {reqTag, reqIndex, {`CACHE_OFFSET_BITS{1'b0}}};

    // Take a beat once per response, not again in its ack cycle
    assign beatEn = (state == cachePkg::stFill) && memRespCyc && !memRespAck;
    assign beatSel = beatCnt[`CACHE_WORD_SEL_BITS-1:0];
    assign beatData = memResp;

    // Ack cycle of the eighth beat, line complete in the buffer
    assign fillEnd = (state == cachePkg::stFill) && memRespAck && (beatCnt == lineBeats);

    // Array updates
    // Read miss writes at fill end, stores write on the address beat ack
    assign wrEn = (fillEnd && !isWrite) || ((state == cachePkg::stWriteAddr) && memReqAck);
    assign wrWay = (state == cachePkg::stLookup) ? victimWay : accWay;
    assign wrIndex = reqIndex;
    assign wrTag = reqTag;
    assign wrLine = line;
    assign invalidateEn = (state == cachePkg::stLookup) && !hit;
    assign mruEn = (state == cachePkg::stRespond) && coreRespAck;
    assign mruWay = accWay;

    // Line buffer commands
    assign loadEn = (state == cachePkg::stLookup) && hit && isWrite;
    assign loadLine = hitLine;
    assign mergeEn = loadEn || (fillEnd && isWrite);
    assign mergeSel = reqSel;
    assign mergeData = reqData;
    assign outSel = (state == cachePkg::stWriteData) ?
                    beatCnt[`CACHE_WORD_SEL_BITS-1:0] : reqSel;

    // Request and response payload
    always_ff @(posedge rwArbiterCacheBus) begin
        if (coreReqAck) begin
            reqAddr <= coreReq;
            reqOp <= coreReqOp;
            reqData <= coreReqData;
        end
        // Hit word straight from the arrays, miss word from the buffer
        if ((state == cachePkg::stLookup) && hit && !isWrite) begin
            coreResp <= hitLine[reqSel];
        end else if (fillEnd && !isWrite) begin
            coreResp <= word;
        end
    end

    always_ff @(posedge rwArbiterCacheBus) begin
        if (rst) begin
            state <= cachePkg::stIdle;
            coreRespCyc <= 1'b0;
            memRespAck <= 1'b0;
            beatCnt <= '0;
            accWay <= 1'b0;
        end else begin
            // One ack per captured fill beat
            memRespAck <= beatEn;
            case (state)
                cachePkg::stIdle: begin
                    if (coreReqCyc) begin
                        state <= cachePkg::stLookup;
                    end
                end
                cachePkg::stLookup: begin
                    beatCnt <= '0;
                    if (hit) begin
                        accWay <= hitWay;
                        if (isWrite) begin
                            state <= cachePkg::stWriteAddr;
                        end else begin
                            coreRespCyc <= 1'b1;
                            state <= cachePkg::stRespond;
                        end
                    end else begin
                        accWay <= victimWay;
                        state <= cachePkg::stFillReq;
                    end
                end
                cachePkg::stFillReq: begin
                    if (memReqAck) begin
                        state <= cachePkg::stFill;
                    end
                end
                cachePkg::stFill: begin
                    if (beatEn) begin
                        beatCnt <= beatCnt + 1'b1;
                    end
                    if (fillEnd) begin
                        beatCnt <= '0;
                        if (isWrite) begin
                            state <= cachePkg::stWriteAddr;
                        end else begin
                            coreRespCyc <= 1'b1;
                            state <= cachePkg::stRespond;
                        end
                    end
                end
                cachePkg::stWriteAddr: begin
                    if (memReqAck) begin
                        state <= cachePkg::stWriteData;
                    end
                end
                cachePkg::stWriteData: begin
                    // Beat held until acked, done after the eighth
                    if (memReqAck) begin
                        if (beatCnt == lineBeats - 1'b1) begin
                            beatCnt <= '0;
                            coreRespCyc <= 1'b1;
                            state <= cachePkg::stRespond;
                        end else begin
                            beatCnt <= beatCnt + 1'b1;
                        end
                    end
                end
                cachePkg::stRespond: begin
                    if (coreRespAck) begin
                        coreRespCyc <= 1'b0;
                        state <= cachePkg::stIdle;
                    end
                end
                default: begin
                    state <= cachePkg::stIdle;
                end
            endcase
        end
    end

    // Memory beat held stable under back-pressure
    memReqHeld: assert property (@(posedge rwArbiterCacheBus) disable iff (rst)
        memReqCyc && !memReqAck |=> memReqCyc && $stable(memReq) && $stable(memReqWrite));

endmodule

// File: verilog/lineBuffer.sv
// Eight-word line register of the data cache
// Loads a way, captures fill beats, merges the store word
// Word select for core response and write-through beats

`timescale 1ns/10ps

module lineBuffer (
    input  logic               rwArbiterCacheBus,
    input  logic               rst,
    input  logic               loadEn,
    input  cachePkg::lineT     loadLine,
    input  logic               beatEn,
    input  cachePkg::wordSelT  beatSel,
    input  cachePkg::wordT     beatData,
    input  logic               mergeEn,
    input  cachePkg::wordSelT  mergeSel,
    input  cachePkg::wordT     mergeData,
    input  cachePkg::wordSelT  outSel,
    output cachePkg::lineT     line,
    output cachePkg::wordT     word
);

    cachePkg::lineT lineReg;
    cachePkg::lineT nextLine;

    // Store word goes over a loaded or filled line in the same cycle
    always_comb begin
        nextLine = lineReg;
        if (loadEn) begin
            nextLine = loadLine;
        end else if (beatEn) begin
            nextLine[beatSel] = beatData;
        end
        if (mergeEn) begin
            nextLine[mergeSel] = mergeData;
        end
    end

    always_ff @(posedge rwArbiterCacheBus) begin
        lineReg <= nextLine;
    end

    assign line = lineReg;

    // Selected word, registered source
    assign word = lineReg[outSel];

    // A way load never lands during a fill
    noLoadInFill: assert property (@(posedge rwArbiterCacheBus) disable iff (rst)
        !(loadEn && beatEn));

endmodule

// File: verilog/cacheArrays.sv
// Storage for both ways of the data cache
// Tags, valid bits, lines and per-set MRU bit
// Registered set read, hit and victim detection

`timescale 1ns/10ps

`include "cache_consts.svh"

module cacheArrays (
    input  logic              rwArbiterCacheBus,
    input  logic              rst,
    input  cachePkg::indexT   rdIndex,
    input  cachePkg::tagT     rdTag,
    input  logic              wrEn,
    input  cachePkg::wayT     wrWay,
    input  cachePkg::indexT   wrIndex,
    input  cachePkg::tagT     wrTag,
    input  cachePkg::lineT    wrLine,
    input  logic              invalidateEn,
    input  logic              mruEn,
    input  cachePkg::wayT     mruWay,
    output logic              hit,
    output cachePkg::wayT     hitWay,
    output cachePkg::wayT     victimWay,
    output cachePkg::lineT    way0Line,
    output cachePkg::lineT    way1Line
);

    localparam int numSets = 1 << `CACHE_INDEX_BITS;

    // Arrays indexed by way, then set
    cachePkg::tagT tagMem [2][numSets];
    cachePkg::lineT lineMem [2][numSets];
    logic [1:0][numSets-1:0] validBits;
    logic [numSets-1:0] mruBits;

    // One set as read in the previous cycle
    cachePkg::tagT tagRd [2];
    logic [1:0] validRd;
    logic mruRd;
    logic [1:0] wayHit;

    // Tag and line storage, plus the set read
    always_ff @(posedge rwArbiterCacheBus) begin
        if (wrEn) begin
            tagMem[wrWay][wrIndex] <= wrTag;
            lineMem[wrWay][wrIndex] <= wrLine;
        end
        tagRd[0] <= tagMem[0][rdIndex];
        tagRd[1] <= tagMem[1][rdIndex];
        way0Line <= lineMem[0][rdIndex];
        way1Line <= lineMem[1][rdIndex];
    end

    // Valid and MRU state
    always_ff @(posedge rwArbiterCacheBus) begin
        if (rst) begin
            validBits <= '0;
            mruBits <= '0;
            validRd <= '0;
            mruRd <= 1'b0;
        end else begin
            // A fill or store makes the way valid
            if (wrEn) begin
                validBits[wrWay][wrIndex] <= 1'b1;
            end
            // Victim dropped before the fill starts
            if (invalidateEn) begin
                validBits[wrWay][wrIndex] <= 1'b0;
            end
            if (mruEn) begin
                mruBits[wrIndex] <= mruWay;
            end
            validRd <= {validBits[1][rdIndex], validBits[0][rdIndex]};
            mruRd <= mruBits[rdIndex];
        end
    end

    // Compare the registered tags against the request
    assign wayHit[0] = validRd[0] && (tagRd[0] == rdTag);
    assign wayHit[1] = validRd[1] && (tagRd[1] == rdTag);
    assign hit = wayHit[0] || wayHit[1];
    assign hitWay = wayHit[1];

    // Empty way first, else the one not used last
    assign victimWay = !validRd[0] ? 1'b0 : (!validRd[1] ? 1'b1 : ~mruRd);

    // A tag lives in at most one way of a set
    oneWayHit: assert property (@(posedge rwArbiterCacheBus) disable iff (rst)
        wayHit[0] |-> !wayHit[1]);

endmodule

// File: verilog/cachePkg.sv
// Shared types of the data cache
// Address, data, line and way types
// Opcode and controller state enums

`include "cache_consts.svh"

package cachePkg;

    typedef logic [`CACHE_ADDR_BITS-1:0] addrT;
    typedef logic [`CACHE_WORD_BITS-1:0] wordT;
    typedef logic [`CACHE_TAG_BITS-1:0] tagT;
    typedef logic [`CACHE_INDEX_BITS-1:0] indexT;
    typedef logic [`CACHE_WORD_SEL_BITS-1:0] wordSelT;

    // Word 0 sits in the low bits
    typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_BITS-1:0] lineT;

    typedef logic wayT;

    typedef enum logic {
        opRead,
        opWrite
    } coreOpE;

    typedef enum logic [2:0] {
        stIdle,
        stLookup,
        stFillReq,
        stFill,
        stWriteAddr,
        stWriteData,
        stRespond
    } cacheStateE;

endpackage

// File: verilog/cache_consts.svh
// Size constants for the two-way data cache
// Address, word, line, index and tag widths

`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Byte address and data word
`define CACHE_ADDR_BITS 64
`define CACHE_WORD_BITS 64

// Eight words per line, 64 bytes
`define CACHE_LINE_WORDS 8
`define CACHE_OFFSET_BITS 6
`define CACHE_WORD_SEL_BITS 3

// 16 sets
`define CACHE_INDEX_BITS 4

// Whatever is left of the address above index and offset
`define CACHE_TAG_BITS (`CACHE_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

`endif
